//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_sm83_alu
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
sm83_alu_pkg.sv
sm83_flags_pkg.sv
sm83_alu_core.sv
sm83_alu_flags.sv
sm83_alu_ctrl.sv
sm83_alu_top.sv
tb_sm83_alu.sv

//--- sm83_alu_cases.txt
# columns: op a b result flags, all hex; op is the alu_op_e value
# flags carry over from line to line, so the order matters
00 3A C6 00 B0
00 12 34 46 00
02 3E 3E 00 C0
02 10 20 F0 50
07 3C 2F 3C 60
07 40 40 40 C0
04 F0 3C 30 20
04 0F F0 00 A0
05 5A 5A 00 80
06 00 81 81 00
10 12 10 12 10
01 FF 00 00 B0
01 01 01 03 00
10 00 10 00 10
03 10 01 0E 60
03 00 01 FF 70
03 05 04 00 C0
10 00 00 00 00
08 85 00 0B 10
0A 40 00 81 00
09 01 00 80 10
0B 02 00 81 00
00 15 27 3C 00
0C 3C 00 42 00
00 99 01 9A 00
0C 9A 00 00 90
02 42 15 2D 60
0C 2D 00 27 40
0D 35 00 CA 60
0E CA 00 CA 10
0F CA 00 CA 00
10 00 FF 00 F0
0F 77 00 77 80
10 AB 0F AB 00

//--- sm83_alu_core.sv
/*
 * Combinational 8-bit datapath of the SM83 arithmetic unit.
 * Produces the result byte plus raw zero, carry, half carry, subtract,
 * shift-out and decimal-adjust carry for the flag registers to pick from.
 */

module sm83_alu_core
	import sm83_alu_pkg::*;
	import sm83_flags_pkg::*;
(
	input  alu_op_e           op,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  logic              carry,
	input  logic              half_carry,
	input  logic              neg,
	output logic [DATA_W-1:0] result,
	output logic              zero_out,
	output logic              carry_out,
	output logic              half_out,
	output logic              sub_out,
	output logic              shift_out,
	output logic              daa_carry_out
);

	logic       cin;
	logic [4:0] lo_add;
	logic [4:0] hi_add;
	logic [4:0] lo_sub;
	logic [4:0] hi_sub;
	logic [7:0] daa_corr;
	logic [7:0] daa_res;
	logic       daa_lo_fix;
	logic [7:0] val;

	// only adc and sbc consume the incoming carry
	assign cin = (op == OP_ADC || op == OP_SBC) ? carry : 1'b0;

	// nibble-wise add, low nibble carry is the half carry
	assign lo_add = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, cin};
	assign hi_add = {1'b0, a[7:4]} + {1'b0, b[7:4]} + {4'b0, lo_add[4]};

	// nibble-wise subtract, bit 4 wraps to 1 on borrow
	assign lo_sub = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'b0, cin};
	assign hi_sub = {1'b0, a[7:4]} - {1'b0, b[7:4]} - {4'b0, lo_sub[4]};

	// decimal adjust
	// after add the correction follows the digits, after sub only H and C
	always_comb begin
		if (!neg) begin
			daa_carry_out = carry || (a > 8'h99);
			daa_lo_fix    = half_carry || (a[3:0] > 4'h9);
		end else begin
			daa_carry_out = carry;
			daa_lo_fix    = half_carry;
		end
		daa_corr = {daa_carry_out ? 4'h6 : 4'h0, daa_lo_fix ? 4'h6 : 4'h0};
		daa_res  = neg ? (a - daa_corr) : (a + daa_corr);
	end

	always_comb begin
		// val is what Z is taken from, result is what goes out
		val       = a;
		result    = a;
		carry_out = 1'b0;
		half_out  = 1'b0;
		sub_out   = 1'b0;
		shift_out = 1'b0;
		case (op)
			OP_ADD, OP_ADC: begin
				val       = {hi_add[3:0], lo_add[3:0]};
				result    = val;
				half_out  = lo_add[4];
				carry_out = hi_add[4];
			end
			OP_SUB, OP_SBC, OP_CP: begin
				val       = {hi_sub[3:0], lo_sub[3:0]};
				// compare keeps a
				result    = (op == OP_CP) ? a : val;
				half_out  = lo_sub[4];
				carry_out = hi_sub[4];
				sub_out   = 1'b1;
			end
			OP_AND: begin
				val    = a & b;
				result = val;
			end
			OP_XOR: begin
				val    = a ^ b;
				result = val;
			end
			OP_OR: begin
				val    = a | b;
				result = val;
			end
			OP_RLC: begin
				result    = {a[6:0], a[7]};
				shift_out = a[7];
			end
			OP_RRC: begin
				result    = {a[0], a[7:1]};
				shift_out = a[0];
			end
			// through-carry rotates
			OP_RL: begin
				result    = {a[6:0], carry};
				shift_out = a[7];
			end
			OP_RR: begin
				result    = {carry, a[7:1]};
				shift_out = a[0];
			end
			OP_DAA: begin
				val    = daa_res;
				result = val;
			end
			OP_CPL: begin
				val    = ~a;
				result = val;
			end
			// flag byte from b, a passes through
			OP_LDF: begin
				carry_out = b[FLAG_C];
				half_out  = b[FLAG_H];
				sub_out   = b[FLAG_N];
			end
			// scf and ccf only touch flags
			default: begin
				result = a;
			end
		endcase
		zero_out = (op == OP_LDF) ? b[FLAG_Z] : (val == '0);
	end

endmodule

//--- sm83_alu_ctrl.sv
/*
 * Operation decoder for the SM83 arithmetic unit.
 * Turns the op strobe into write, set, clear and select controls for the
 * flag registers and delays the strobe into result_valid.
 */

module sm83_alu_ctrl
	import sm83_alu_pkg::*;
	import sm83_flags_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     op_valid,
	input  alu_op_e  op,
	output logic     result_valid,
	output logic     flags_bus,
	output logic     flags_alu,
	output logic     zero_we,
	output logic     zero_clr,
	output logic     neg_we,
	output logic     neg_set,
	output logic     neg_clr,
	output logic     half_carry_we,
	output logic     half_carry_set,
	output logic     half_carry_cpl,
	output logic     daa_carry_we,
	output logic     carry_we,
	output logic     sec_carry_we,
	output sec_src_e sec_src,
	output logic     sec_carry_sel,
	output logic     carry_set,
	output logic     carry_cpl
);

	always_comb begin
		flags_bus      = 1'b0;
		flags_alu      = 1'b0;
		zero_we        = 1'b0;
		zero_clr       = 1'b0;
		neg_we         = 1'b0;
		neg_set        = 1'b0;
		neg_clr        = 1'b0;
		half_carry_we  = 1'b0;
		half_carry_set = 1'b0;
		// no sm83 op flips H
		half_carry_cpl = 1'b0;
		daa_carry_we   = 1'b0;
		carry_we       = 1'b0;
		sec_carry_we   = 1'b0;
		sec_src        = SEC_ALU;
		carry_set      = 1'b0;
		carry_cpl      = 1'b0;
		if (op_valid) begin
			// H and its daa copy always written together
			case (op)
				OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CP,
				OP_AND, OP_XOR, OP_OR: begin
					flags_alu      = 1'b1;
					zero_we        = 1'b1;
					neg_we         = 1'b1;
					half_carry_we  = 1'b1;
					daa_carry_we   = 1'b1;
					carry_we       = 1'b1;
					// logic ops clear N and only AND sets H
					neg_clr        = (op == OP_AND || op == OP_XOR || op == OP_OR);
					half_carry_set = (op == OP_AND);
				end
				// rotates clear Z N H, carry goes to the secondary reg
				OP_RLC, OP_RRC, OP_RL, OP_RR: begin
					flags_alu     = 1'b1;
					zero_we       = 1'b1;
					zero_clr      = 1'b1;
					neg_we        = 1'b1;
					neg_clr       = 1'b1;
					half_carry_we = 1'b1;
					daa_carry_we  = 1'b1;
					sec_carry_we  = 1'b1;
					sec_src       = SEC_SHIFT;
				end
				// N untouched, H cleared via datapath zero
				OP_DAA: begin
					flags_alu     = 1'b1;
					zero_we       = 1'b1;
					half_carry_we = 1'b1;
					daa_carry_we  = 1'b1;
					sec_carry_we  = 1'b1;
					sec_src       = SEC_DAA;
				end
				OP_CPL: begin
					flags_alu      = 1'b1;
					neg_we         = 1'b1;
					neg_set        = 1'b1;
					half_carry_we  = 1'b1;
					half_carry_set = 1'b1;
					daa_carry_we   = 1'b1;
				end
				OP_SCF, OP_CCF: begin
					flags_alu     = 1'b1;
					neg_we        = 1'b1;
					neg_clr       = 1'b1;
					half_carry_we = 1'b1;
					daa_carry_we  = 1'b1;
					carry_we      = 1'b1;
					carry_set     = (op == OP_SCF);
					carry_cpl     = (op == OP_CCF);
				end
				OP_LDF: begin
					flags_bus     = 1'b1;
					zero_we       = 1'b1;
					neg_we        = 1'b1;
					half_carry_we = 1'b1;
					daa_carry_we  = 1'b1;
					carry_we      = 1'b1;
				end
				default: begin
					flags_alu = 1'b0;
				end
			endcase
		end
	end

	// carry select follows the last carry write
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			sec_carry_sel <= 1'b0;
		else if (sec_carry_we)
			sec_carry_sel <= 1'b1;
		else if (carry_we)
			sec_carry_sel <= 1'b0;
	end

	// result and flags land one cycle after the strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			result_valid <= 1'b0;
		else
			result_valid <= op_valid;
	end

	// an undefined op would strobe result_valid with no flag write
	assert property (@(posedge clk) disable iff (!arst_n) op_valid |-> (op <= OP_LDF));

endmodule

//--- sm83_alu_flags.sv
/*
 * Flag registers of the SM83 arithmetic unit.
 * Holds Z, N, H, a half carry copy for decimal adjust and a primary and
 * secondary carry. Loads from the datapath or from the data bus; carry and
 * half carry can be set or complemented on the output side.
 */

module sm83_alu_flags
	import sm83_flags_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] din,
	input  logic       flags_bus,
	input  logic       flags_alu,
	input  logic       zero_we,
	input  logic       zero_clr,
	input  logic       neg_we,
	input  logic       neg_set,
	input  logic       neg_clr,
	input  logic       half_carry_we,
	input  logic       half_carry_set,
	input  logic       half_carry_cpl,
	input  logic       daa_carry_we,
	input  logic       carry_we,
	input  logic       sec_carry_we,
	input  sec_src_e   sec_src,
	input  logic       sec_carry_sel,
	input  logic       carry_set,
	input  logic       carry_cpl,
	input  logic       zero_in,
	input  logic       carry_in,
	input  logic       half_in,
	input  logic       shift_out_in,
	input  logic       daa_carry_in,
	input  logic       sign_in,
	output logic [7:0] dout,
	output logic       zero,
	output logic       half_carry,
	output logic       daa_carry,
	output logic       neg,
	output logic       carry,
	output logic       pri_carry
);

	logic hc_reg;
	logic sec_c_reg;
	logic c_stored;
	logic h_src;
	logic h_next;
	logic c_next;
	logic any_we;

	// carry as stored, before output-side set or complement
	assign c_stored = sec_carry_sel ? sec_c_reg : pri_carry;

	// output-side modifiers
	assign carry      = (carry_set | c_stored) ^ carry_cpl;
	assign half_carry = (half_carry_set | hc_reg) ^ half_carry_cpl;

	// H written post-set, so the value holds once the strobe is gone
	assign h_src  = flags_bus ? din[FLAG_H] : half_in;
	assign h_next = (half_carry_set | h_src) ^ half_carry_cpl;

	// scf and ccf store the modified carry back into the primary reg
	always_comb begin
		if (carry_set || carry_cpl)
			c_next = carry;
		else if (flags_bus)
			c_next = din[FLAG_C];
		else
			c_next = carry_in;
	end

	// bus view comes from stored state only
	// a following strobe's set or cpl must not leak into this byte
	assign dout[FLAG_Z] = zero;
	assign dout[FLAG_N] = neg;
	assign dout[FLAG_H] = hc_reg;
	assign dout[FLAG_C] = c_stored;
	assign dout[3:0]    = 4'h0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			zero <= 1'b0;
		end else if (zero_we) begin
			if (zero_clr)
				zero <= 1'b0;
			else
				zero <= flags_bus ? din[FLAG_Z] : zero_in;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			neg <= 1'b0;
		end else if (neg_we) begin
			if (neg_clr)
				neg <= 1'b0;
			else if (neg_set)
				neg <= 1'b1;
			else
				neg <= flags_bus ? din[FLAG_N] : sign_in;
		end
	end

	// visible H and its decimal adjust copy
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hc_reg    <= 1'b0;
			daa_carry <= 1'b0;
		end else begin
			if (half_carry_we)
				hc_reg <= h_next;
			if (daa_carry_we)
				daa_carry <= h_next;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pri_carry <= 1'b0;
		else if (carry_we)
			pri_carry <= c_next;
	end

	// secondary carry for rotates and daa
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sec_c_reg <= 1'b0;
		end else if (sec_carry_we) begin
			case (sec_src)
				SEC_SHIFT: sec_c_reg <= shift_out_in;
				SEC_DAA:   sec_c_reg <= daa_carry_in;
				default:   sec_c_reg <= carry_in;
			endcase
		end
	end

	assign any_we = zero_we | neg_we | half_carry_we | daa_carry_we | carry_we | sec_carry_we;

	// every write names exactly one source
	assert property (@(posedge clk) disable iff (!arst_n) any_we |-> (flags_bus ^ flags_alu));

	// only one of the two carry regs loads per strobe
	assert property (@(posedge clk) disable iff (!arst_n) !(carry_we && sec_carry_we));

endmodule

//--- sm83_alu_pkg.sv
/*
 * Operation codes and data width of the SM83 8-bit arithmetic unit.
 * Imported by the control decoder, the datapath and the top level.
 * Each operation's numeric value is its position in the enum, starting at 0.
 */

package sm83_alu_pkg;

	// width is fixed by the flag byte format
	parameter int DATA_W = 8;

	// operation select, 5 bits wide
	typedef enum logic [4:0] {
		// two-operand arithmetic
		OP_ADD,
		OP_ADC,
		OP_SUB,
		OP_SBC,
		// logic ops
		OP_AND,
		OP_XOR,
		OP_OR,
		// subtract with the result dropped
		OP_CP,
		// accumulator rotates
		OP_RLC,
		OP_RRC,
		OP_RL,
		OP_RR,
		// bcd correction after add or sub
		OP_DAA,
		// single-operand and flag-only ops
		OP_CPL,
		OP_SCF,
		OP_CCF,
		// flag byte taken from operand b, as on pop af
		OP_LDF
	} alu_op_e;

endpackage

//--- sm83_alu_top.sv
/*
 * Top level of the SM83 8-bit arithmetic unit.
 * Strobe op_valid with op, a and b; one cycle later result_valid is high
 * and result and flags carry the outcome. No back-pressure.
 */

module sm83_alu_top
	import sm83_alu_pkg::*;
	import sm83_flags_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              op_valid,
	input  alu_op_e           op,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	output logic              result_valid,
	output logic [DATA_W-1:0] result,
	output logic [DATA_W-1:0] flags
);

	logic              flags_bus;
	logic              flags_alu;
	logic              zero_we;
	logic              zero_clr;
	logic              neg_we;
	logic              neg_set;
	logic              neg_clr;
	logic              half_carry_we;
	logic              half_carry_set;
	logic              half_carry_cpl;
	logic              daa_carry_we;
	logic              carry_we;
	logic              sec_carry_we;
	sec_src_e          sec_src;
	logic              sec_carry_sel;
	logic              carry_set;
	logic              carry_cpl;
	logic [DATA_W-1:0] alu_result;
	logic              zero_out;
	logic              carry_out;
	logic              half_out;
	logic              sub_out;
	logic              shift_out;
	logic              daa_carry_out;
	logic              carry;
	logic              daa_carry;
	logic              neg;

	sm83_alu_ctrl u_ctrl (
		.clk            (clk),
		.arst_n         (arst_n),
		.op_valid       (op_valid),
		.op             (op),
		.result_valid   (result_valid),
		.flags_bus      (flags_bus),
		.flags_alu      (flags_alu),
		.zero_we        (zero_we),
		.zero_clr       (zero_clr),
		.neg_we         (neg_we),
		.neg_set        (neg_set),
		.neg_clr        (neg_clr),
		.half_carry_we  (half_carry_we),
		.half_carry_set (half_carry_set),
		.half_carry_cpl (half_carry_cpl),
		.daa_carry_we   (daa_carry_we),
		.carry_we       (carry_we),
		.sec_carry_we   (sec_carry_we),
		.sec_src        (sec_src),
		.sec_carry_sel  (sec_carry_sel),
		.carry_set      (carry_set),
		.carry_cpl      (carry_cpl)
	);

	// half carry into the datapath is the daa copy
	sm83_alu_core u_core (
		.op            (op),
		.a             (a),
		.b             (b),
		.carry         (carry),
		.half_carry    (daa_carry),
		.neg           (neg),
		.result        (alu_result),
		.zero_out      (zero_out),
		.carry_out     (carry_out),
		.half_out      (half_out),
		.sub_out       (sub_out),
		.shift_out     (shift_out),
		.daa_carry_out (daa_carry_out)
	);

	// flag byte load reads operand b
	sm83_alu_flags u_flags (
		.clk            (clk),
		.arst_n         (arst_n),
		.din            (b),
		.flags_bus      (flags_bus),
		.flags_alu      (flags_alu),
		.zero_we        (zero_we),
		.zero_clr       (zero_clr),
		.neg_we         (neg_we),
		.neg_set        (neg_set),
		.neg_clr        (neg_clr),
		.half_carry_we  (half_carry_we),
		.half_carry_set (half_carry_set),
		.half_carry_cpl (half_carry_cpl),
		.daa_carry_we   (daa_carry_we),
		.carry_we       (carry_we),
		.sec_carry_we   (sec_carry_we),
		.sec_src        (sec_src),
		.sec_carry_sel  (sec_carry_sel),
		.carry_set      (carry_set),
		.carry_cpl      (carry_cpl),
		.zero_in        (zero_out),
		.carry_in       (carry_out),
		.half_in        (half_out),
		.shift_out_in   (shift_out),
		.daa_carry_in   (daa_carry_out),
		.sign_in        (sub_out),
		.dout           (flags),
		.zero           (),
		.half_carry     (),
		.daa_carry      (daa_carry),
		.neg            (neg),
		.carry          (carry),
		.pri_carry      ()
	);

	// result byte held until the next strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			result <= '0;
		else if (op_valid)
			result <= alu_result;
	end

endmodule

//--- sm83_flags_pkg.sv
/*
 * Flag byte layout and secondary carry source select.
 * Imported by the control decoder, the datapath and the flag registers.
 * Bits 3 to 0 of the flag byte always read as zero.
 */

package sm83_flags_pkg;

	// bit positions within the flag byte
	parameter int FLAG_Z = 7;
	parameter int FLAG_N = 6;
	parameter int FLAG_H = 5;
	parameter int FLAG_C = 4;

	// what the secondary carry register loads on its write
	typedef enum logic [1:0] {
		SEC_ALU,
		SEC_SHIFT,
		SEC_DAA
	} sec_src_e;

endpackage

//--- tb_sm83_alu.sv
/*
 * Testbench for the SM83 arithmetic unit.
 * Reads operations and expected outcomes from sm83_alu_cases.txt, strobes
 * them into the DUT with random idle gaps and checks result and flags in
 * the cycle where result_valid is high.
 */

module tb_sm83_alu
	import sm83_alu_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 8;
	localparam int unsigned SEED = 32'h76d6062c;
	localparam string CASES_FILE = "sm83_alu_cases.txt";

	logic              clk;
	logic              arst_n;
	logic              op_valid;
	alu_op_e           op;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic              result_valid;
	logic [DATA_W-1:0] result;
	logic [DATA_W-1:0] flags;

	// cases as read from the file
	logic [4:0] case_op[$];
	logic [7:0] case_a[$];
	logic [7:0] case_b[$];
	logic [7:0] case_res[$];
	logic [7:0] case_flg[$];

	// outcomes in flight, tagged with the cycle they are due in
	int unsigned due_cyc[$];
	logic [7:0]  due_res[$];
	logic [7:0]  due_flg[$];
	int          due_idx[$];

	int unsigned cyc = 0;
	int          errors = 0;
	bit          loaded = 1'b0;

	sm83_alu_top dut0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.op_valid     (op_valid),
		.op           (op),
		.a            (a),
		.b            (b),
		.result_valid (result_valid),
		.result       (result),
		.flags        (flags)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// cycle count, bumped on each rising edge
	always @(posedge clk)
		cyc <= cyc + 1;

	// lines that do not parse as five hex fields are comments
	task automatic read_cases();
		int         fd;
		int         n;
		string      line;
		logic [7:0] f_op;
		logic [7:0] f_a;
		logic [7:0] f_b;
		logic [7:0] f_res;
		logic [7:0] f_flg;
		fd = $fopen(CASES_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the cases file %s", CASES_FILE);
			return;
		end
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_flg);
			if (n == 5) begin
				case_op.push_back(f_op[4:0]);
				case_a.push_back(f_a);
				case_b.push_back(f_b);
				case_res.push_back(f_res);
				case_flg.push_back(f_flg);
			end
		end
		$fclose(fd);
	endtask

	task automatic idle_cycles(input int unsigned n);
		repeat (n) begin
			@(posedge clk);
			#1;
			op_valid = 1'b0;
		end
	endtask

	// one strobe, outcome due one cycle after the sampling edge
	task automatic drive_case(input int idx);
		op_valid = 1'b1;
		op       = alu_op_e'(case_op[idx]);
		a        = case_a[idx];
		b        = case_b[idx];
		due_cyc.push_back(cyc + 1);
		due_res.push_back(case_res[idx]);
		due_flg.push_back(case_flg[idx]);
		due_idx.push_back(idx);
	endtask

	// mid-cycle, away from both edges
	task automatic check_cycle();
		if (due_cyc.size() != 0 && due_cyc[0] == cyc) begin
			assert (result_valid) else begin
				errors++;
				$display("Case %0d: result_valid did not rise one cycle after the strobe",
					due_idx[0]);
			end
			assert (result == due_res[0]) else begin
				errors++;
				$display("Mismatch result: got %h, expected %h (case %0d)",
					result, due_res[0], due_idx[0]);
			end
			assert (flags == due_flg[0]) else begin
				errors++;
				$display("Mismatch flags: got %h, expected %h (case %0d)",
					flags, due_flg[0], due_idx[0]);
			end
			void'(due_cyc.pop_front());
			void'(due_res.pop_front());
			void'(due_flg.pop_front());
			void'(due_idx.pop_front());
		end else begin
			assert (!result_valid) else begin
				errors++;
				$display("result_valid was high in cycle %0d with no strobe pending", cyc);
			end
		end
		// low nibble is hardwired
		assert (flags[3:0] == 4'h0) else begin
			errors++;
			$display("Mismatch flags[3:0]: got %h, expected 0", flags[3:0]);
		end
	endtask

	always @(negedge clk)
		check_cycle();

	// limit scales with the case count
	initial begin
		int limit;
		wait (loaded);
		limit = case_op.size() * 5 + 50;
		#(limit * CLK_PERIOD);
		$display("Timeout: run did not end within %0d cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int unsigned gap;
		arst_n   = 1'b0;
		op_valid = 1'b0;
		op       = OP_ADD;
		a        = '0;
		b        = '0;
		void'($urandom(SEED));
		read_cases();
		if (case_op.size() == 0) begin
			errors++;
			$display("No cases were read from %s", CASES_FILE);
		end
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		// idle after reset, nothing strobed yet
		repeat (2) @(posedge clk);
		#1;
		assert (flags == 8'h00) else begin
			errors++;
			$display("Mismatch flags: got %h, expected 00 after reset", flags);
		end
		assert (result == 8'h00) else begin
			errors++;
			$display("Mismatch result: got %h, expected 00 after reset", result);
		end
		for (int i = 0; i < case_op.size(); i++) begin
			// gap of 0 gives back-to-back strobes
			gap = $urandom % 4;
			idle_cycles(gap);
			@(posedge clk);
			#1;
			drive_case(i);
		end
		idle_cycles(1);
		while (due_cyc.size() != 0)
			@(negedge clk);
		// catch a stray result_valid
		idle_cycles(2);
		$display("%0d cases run, %0d errors", case_op.size(), errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
